// File: source/pi1_pkg.sv
// pi1 bus definitions
package pi1_pkg;

	// **********************************************************************
	// Bus widths
	// **********************************************************************

	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;
	localparam int ADDR_W = 30; // Word address without the byte offset.

	typedef logic [DATA_W-1:0] pi1_data_t;
	typedef logic [ADDR_W-1:0] pi1_addr_t;
	typedef logic [SEL_W-1:0]  pi1_sel_t;
	typedef logic [1:0]        pi1_op_t;

	// **********************************************************************
	// Operation codes
	// **********************************************************************

	localparam pi1_op_t PI_NOOP = 2'd0;
	localparam pi1_op_t PI_WROP = 2'd1;
	localparam pi1_op_t PI_RDOP = 2'd2;
	localparam pi1_op_t PI_RWOP = 2'd3; // Returns the old word, stores the new one.

	// **********************************************************************
	// Memory map of the subsystem
	// **********************************************************************

	localparam int MEM0_SIZE  = 256; // Words.
	localparam int MEM0_DELAY = 0;

	localparam int MEM1_SIZE  = 128; // Word region placed right after slave 0.
	localparam int MEM1_DELAY = 2;

endpackage

// File: source/pi1_ram.sv
// Single-port word RAM
`timescale 1ns/1ns

module pi1_ram #(
	parameter int SIZE = 256
) (
	input  logic                clk_i,
	input  logic                we_i,
	input  pi1_pkg::pi1_addr_t  addr_i,
	input  pi1_pkg::pi1_data_t  data_i,
	output pi1_pkg::pi1_data_t  data_o
);

	localparam int IDX_W = (SIZE > 1) ? $clog2(SIZE) : 1;

	pi1_pkg::pi1_data_t mem [SIZE];
	logic [IDX_W-1:0]   idx;

	assign idx = addr_i[IDX_W-1:0]; // Upper address bits are ignored.

	assign data_o = mem[idx];

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[idx] <= data_i;
		end
	end

endmodule

// File: source/pi1_smem.sv
// pi1 memory slave
`timescale 1ns/1ns

module pi1_smem #(
	parameter int SIZE  = 256,
	parameter int DELAY = 0
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  pi1_pkg::pi1_op_t    pi1_op_i,
	input  pi1_pkg::pi1_addr_t  pi1_addr_i,
	input  pi1_pkg::pi1_data_t  pi1_data_i,
	input  pi1_pkg::pi1_sel_t   pi1_sel_i,
	output pi1_pkg::pi1_data_t  pi1_data_o,
	output logic                pi1_rdy_o,
	output pi1_pkg::pi1_addr_t  pi1_mapsz_o
);

	localparam int CNT_W = (DELAY > 0) ? $clog2(DELAY + 1) : 1;

	logic [CNT_W-1:0]   wait_cnt;
	logic               accept;
	logic               rd_en;
	logic               wr_en;
	pi1_pkg::pi1_data_t bit_mask;
	pi1_pkg::pi1_data_t ram_q;
	pi1_pkg::pi1_data_t ram_d;
	pi1_pkg::pi1_data_t rd_data_q;

	assign pi1_mapsz_o = pi1_pkg::pi1_addr_t'(SIZE);

	assign pi1_rdy_o = (wait_cnt == '0);

	// **********************************************************************
	// Op decode
	// **********************************************************************

	assign accept = pi1_rdy_o && (pi1_op_i != pi1_pkg::PI_NOOP);
	assign rd_en  = pi1_rdy_o &&
		(pi1_op_i == pi1_pkg::PI_RDOP || pi1_op_i == pi1_pkg::PI_RWOP);
	assign wr_en  = pi1_rdy_o &&
		(pi1_op_i == pi1_pkg::PI_WROP || pi1_op_i == pi1_pkg::PI_RWOP);

	// One select bit covers eight data bits.
	always_comb begin
		for (int i = 0; i < pi1_pkg::SEL_W; i++) begin
			bit_mask[8*i +: 8] = {8{pi1_sel_i[i]}};
		end
	end

	assign ram_d = (pi1_data_i & bit_mask) | (ram_q & ~bit_mask); // Keep unselected bytes.

	pi1_ram #(
		.SIZE (SIZE)
	) u_ram (
		.clk_i  (clk_i),
		.we_i   (wr_en),
		.addr_i (pi1_addr_i),
		.data_i (ram_d),
		.data_o (ram_q)
	);

	// **********************************************************************
	// Read data and wait states
	// **********************************************************************

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_data_q <= '0;
		end else if (rd_en) begin
			rd_data_q <= ram_q; // Word as it was before this access.
		end
	end

	assign pi1_data_o = pi1_rdy_o ? rd_data_q : '0;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wait_cnt <= '0;
		end else if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - 1'b1;
		end else if (accept) begin
			wait_cnt <= CNT_W'(DELAY); // Ready stays low for DELAY cycles.
		end
	end

endmodule

// File: source/pi1_decoder.sv
// pi1 two-slave address decoder
`timescale 1ns/1ns

module pi1_decoder (
	input  logic                clk_i,
	input  logic                rst_i,
	input  pi1_pkg::pi1_op_t    pi1_op_i,
	input  pi1_pkg::pi1_addr_t  pi1_addr_i,
	input  pi1_pkg::pi1_data_t  pi1_data_i,
	input  pi1_pkg::pi1_sel_t   pi1_sel_i,
	output pi1_pkg::pi1_data_t  pi1_data_o,
	output logic                pi1_rdy_o,
	output logic                pi1_err_o,
	output pi1_pkg::pi1_addr_t  pi1_mapsz_o,
	output pi1_pkg::pi1_op_t    s0_op_o,
	output pi1_pkg::pi1_addr_t  s0_addr_o,
	output pi1_pkg::pi1_data_t  s0_data_o,
	output pi1_pkg::pi1_sel_t   s0_sel_o,
	input  pi1_pkg::pi1_data_t  s0_data_i,
	input  logic                s0_rdy_i,
	input  pi1_pkg::pi1_addr_t  s0_mapsz_i,
	output pi1_pkg::pi1_op_t    s1_op_o,
	output pi1_pkg::pi1_addr_t  s1_addr_o,
	output pi1_pkg::pi1_data_t  s1_data_o,
	output pi1_pkg::pi1_sel_t   s1_sel_o,
	input  pi1_pkg::pi1_data_t  s1_data_i,
	input  logic                s1_rdy_i,
	input  pi1_pkg::pi1_addr_t  s1_mapsz_i
);

	pi1_pkg::pi1_addr_t s1_offset;
	logic               hit0;
	logic               hit1;
	logic               miss;
	logic               accept;
	logic               own1_q;  // Slave 1 owns the access.
	logic               none_q;  // No slave owns the access.
	logic               err_q;

	// **********************************************************************
	// Address decode
	// **********************************************************************

	assign s1_offset = pi1_addr_i - s0_mapsz_i;
	assign hit0      = (pi1_addr_i < s0_mapsz_i);
	assign hit1      = !hit0 && (s1_offset < s1_mapsz_i); // No underflow once hit0 is low.
	assign miss      = !hit0 && !hit1;

	assign accept = pi1_rdy_o && (pi1_op_i != pi1_pkg::PI_NOOP);

	assign s0_op_o   = (pi1_rdy_o && hit0) ? pi1_op_i : pi1_pkg::PI_NOOP;
	assign s0_addr_o = pi1_addr_i;
	assign s0_data_o = pi1_data_i;
	assign s0_sel_o  = pi1_sel_i;

	assign s1_op_o   = (pi1_rdy_o && hit1) ? pi1_op_i : pi1_pkg::PI_NOOP;
	assign s1_addr_o = s1_offset;
	assign s1_data_o = pi1_data_i;
	assign s1_sel_o  = pi1_sel_i;

	// **********************************************************************
	// Owner tracking and response mux
	// **********************************************************************

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			own1_q <= 1'b0;
			none_q <= 1'b0;
			err_q  <= 1'b0;
		end else begin
			err_q <= accept && miss; // One-cycle pulse.
			if (accept) begin
				own1_q <= hit1;
				none_q <= miss;
			end
		end
	end

	assign pi1_rdy_o  = none_q || (own1_q ? s1_rdy_i : s0_rdy_i);
	assign pi1_data_o = none_q ? '0 : (own1_q ? s1_data_i : s0_data_i);
	assign pi1_err_o  = err_q;

	assign pi1_mapsz_o = s0_mapsz_i + s1_mapsz_i; // Slaves sit back to back.

endmodule

// File: source/pi1_mem_top.sv
// pi1 memory subsystem top
`timescale 1ns/1ns

module pi1_mem_top (
	input  logic                clk_i,
	input  logic                rst_i,
	input  pi1_pkg::pi1_op_t    pi1_op_i,
	input  pi1_pkg::pi1_addr_t  pi1_addr_i,
	input  pi1_pkg::pi1_data_t  pi1_data_i,
	input  pi1_pkg::pi1_sel_t   pi1_sel_i,
	output pi1_pkg::pi1_data_t  pi1_data_o,
	output logic                pi1_rdy_o,
	output logic                pi1_err_o,
	output pi1_pkg::pi1_addr_t  pi1_mapsz_o
);

	pi1_pkg::pi1_op_t   s0_op, s1_op;
	pi1_pkg::pi1_addr_t s0_addr, s1_addr;
	pi1_pkg::pi1_data_t s0_wdata, s1_wdata;
	pi1_pkg::pi1_sel_t  s0_sel, s1_sel;
	pi1_pkg::pi1_data_t s0_rdata, s1_rdata;
	logic               s0_rdy, s1_rdy;
	pi1_pkg::pi1_addr_t s0_mapsz, s1_mapsz;

	pi1_decoder u_decoder (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_i   (pi1_sel_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.pi1_err_o   (pi1_err_o),
		.pi1_mapsz_o (pi1_mapsz_o),
		.s0_op_o     (s0_op),
		.s0_addr_o   (s0_addr),
		.s0_data_o   (s0_wdata),
		.s0_sel_o    (s0_sel),
		.s0_data_i   (s0_rdata),
		.s0_rdy_i    (s0_rdy),
		.s0_mapsz_i  (s0_mapsz),
		.s1_op_o     (s1_op),
		.s1_addr_o   (s1_addr),
		.s1_data_o   (s1_wdata),
		.s1_sel_o    (s1_sel),
		.s1_data_i   (s1_rdata),
		.s1_rdy_i    (s1_rdy),
		.s1_mapsz_i  (s1_mapsz)
	);

	// Zero-wait slave at the bottom of the map.
	pi1_smem #(
		.SIZE  (pi1_pkg::MEM0_SIZE),
		.DELAY (pi1_pkg::MEM0_DELAY)
	) u_mem0 (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.pi1_op_i    (s0_op),
		.pi1_addr_i  (s0_addr),
		.pi1_data_i  (s0_wdata),
		.pi1_sel_i   (s0_sel),
		.pi1_data_o  (s0_rdata),
		.pi1_rdy_o   (s0_rdy),
		.pi1_mapsz_o (s0_mapsz)
	);

	pi1_smem #(
		.SIZE  (pi1_pkg::MEM1_SIZE),
		.DELAY (pi1_pkg::MEM1_DELAY)
	) u_mem1 (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.pi1_op_i    (s1_op),
		.pi1_addr_i  (s1_addr),
		.pi1_data_i  (s1_wdata),
		.pi1_sel_i   (s1_sel),
		.pi1_data_o  (s1_rdata),
		.pi1_rdy_o   (s1_rdy),
		.pi1_mapsz_o (s1_mapsz)
	);

endmodule

// File: verif/pi1_smem_asserts.sv
// pi1 slave assertions
`timescale 1ns/1ns

module pi1_smem_asserts #(
	parameter int SIZE  = 256,
	parameter int DELAY = 0
) (
	input logic               clk_i,
	input logic               rst_i,
	input pi1_pkg::pi1_op_t   op_i,
	input pi1_pkg::pi1_data_t data_i,
	input logic               rdy_i,
	input pi1_pkg::pi1_addr_t mapsz_i
);

	int fail_cnt = 0; // Failed assertions of this instance.

	data_gated: assert property (@(posedge clk_i) disable iff (rst_i)
		!rdy_i |-> (data_i == '0))
	else begin
		fail_cnt++;
		$error("Read data is not zero while ready is low.");
	end

	wait_start: assert property (@(posedge clk_i) disable iff (rst_i)
		(DELAY > 0 && rdy_i && op_i != pi1_pkg::PI_NOOP) |=> !rdy_i)
	else begin
		fail_cnt++;
		$error("Ready did not drop after an accepted op.");
	end

	map_size: assert property (@(posedge clk_i) mapsz_i == pi1_pkg::pi1_addr_t'(SIZE))
	else begin
		fail_cnt++;
		$error("Map size differs from SIZE.");
	end

endmodule

bind pi1_smem pi1_smem_asserts #(
	.SIZE  (SIZE),
	.DELAY (DELAY)
) u_smem_asserts (
	.clk_i   (clk_i),
	.rst_i   (rst_i),
	.op_i    (pi1_op_i),
	.data_i  (pi1_data_o),
	.rdy_i   (pi1_rdy_o),
	.mapsz_i (pi1_mapsz_o)
);

// File: verif/tb_pi1_mem.sv
// pi1 memory subsystem testbench
`timescale 1ns/1ns

module tb_pi1_mem;

	localparam int MAP_WORDS      = pi1_pkg::MEM0_SIZE + pi1_pkg::MEM1_SIZE;
	localparam int TIMEOUT_CYCLES = 32;

	logic               clk_i;
	logic               rst_i;
	pi1_pkg::pi1_op_t   pi1_op_i;
	pi1_pkg::pi1_addr_t pi1_addr_i;
	pi1_pkg::pi1_data_t pi1_data_i;
	pi1_pkg::pi1_sel_t  pi1_sel_i;
	pi1_pkg::pi1_data_t pi1_data_o;
	logic               pi1_rdy_o;
	logic               pi1_err_o;
	pi1_pkg::pi1_addr_t pi1_mapsz_o;

	pi1_pkg::pi1_data_t model [MAP_WORDS]; // Expected content of both regions.
	int                 checks;
	int                 errors;
	int                 assert_fails;

	pi1_mem_top u_pi1_mem_top (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_i   (pi1_sel_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.pi1_err_o   (pi1_err_o),
		.pi1_mapsz_o (pi1_mapsz_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// **********************************************************************
	// Compare tasks and reference rules
	// **********************************************************************

	task automatic check_data(input string name, input pi1_pkg::pi1_data_t got,
		input pi1_pkg::pi1_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input pi1_pkg::pi1_addr_t got,
		input pi1_pkg::pi1_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Selected bytes take the new data, the others keep the old word.
	function automatic pi1_pkg::pi1_data_t merge_word(input pi1_pkg::pi1_data_t old_w,
		input pi1_pkg::pi1_data_t new_w, input pi1_pkg::pi1_sel_t sel);
		pi1_pkg::pi1_data_t res;
		res = old_w;
		for (int b = 0; b < pi1_pkg::SEL_W; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic int expected_waits(input int idx);
		if (idx < pi1_pkg::MEM0_SIZE) begin
			return pi1_pkg::MEM0_DELAY;
		end else if (idx < MAP_WORDS) begin
			return pi1_pkg::MEM1_DELAY;
		end else begin
			return 0; // Misses are answered by the decoder at once.
		end
	endfunction

	// **********************************************************************
	// Bus access
	// **********************************************************************

	task automatic bus_access(input pi1_pkg::pi1_op_t op, input int idx,
		input pi1_pkg::pi1_data_t wdata, input pi1_pkg::pi1_sel_t sel,
		output pi1_pkg::pi1_data_t rdata, output int waits, output logic err_seen);
		int   cnt;
		logic done;
		@(posedge clk_i);
		pi1_op_i   <= op;
		pi1_addr_i <= pi1_pkg::pi1_addr_t'(idx);
		pi1_data_i <= wdata;
		pi1_sel_i  <= sel;
		cnt  = 0;
		done = 1'b0;
		while (!done && cnt < TIMEOUT_CYCLES) begin
			@(negedge clk_i);
			done = pi1_rdy_o; // Accepted on the next rising edge.
			cnt++;
		end
		if (!done) begin
			errors++;
			$display("ERROR: ready stayed low, the op at word 0x%0h was never accepted", idx);
		end
		@(posedge clk_i);
		pi1_op_i <= pi1_pkg::PI_NOOP;
		cnt      = 0;
		done     = 1'b0;
		waits    = 0;
		err_seen = 1'b0;
		while (!done && cnt < TIMEOUT_CYCLES) begin
			@(negedge clk_i);
			if (cnt == 0) begin
				err_seen = pi1_err_o;
			end
			if (pi1_rdy_o) begin
				done = 1'b1;
			end else begin
				waits++;
				check_data("pi1_data_o while not ready", pi1_data_o, '0);
			end
			cnt++;
		end
		if (!done) begin
			errors++;
			$display("ERROR: ready did not return within %0d cycles after word 0x%0h",
				TIMEOUT_CYCLES, idx);
		end
		rdata = pi1_data_o;
	endtask

	task automatic access_word(input pi1_pkg::pi1_op_t op, input int idx,
		input pi1_pkg::pi1_data_t wdata, input pi1_pkg::pi1_sel_t sel);
		pi1_pkg::pi1_data_t rdata;
		pi1_pkg::pi1_data_t exp_rd;
		int                 waits;
		logic               err_seen;
		logic               in_map;
		logic               is_rd;
		logic               is_wr;
		in_map = (idx < MAP_WORDS);
		is_rd  = (op == pi1_pkg::PI_RDOP) || (op == pi1_pkg::PI_RWOP);
		is_wr  = (op == pi1_pkg::PI_WROP) || (op == pi1_pkg::PI_RWOP);
		exp_rd = (in_map && is_rd) ? model[idx] : '0;
		bus_access(op, idx, wdata, sel, rdata, waits, err_seen);
		if (in_map && is_wr) begin
			model[idx] = merge_word(model[idx], wdata, sel);
		end
		if (is_rd || !in_map) begin
			check_data($sformatf("pi1_data_o word 0x%0h", idx), rdata, exp_rd);
		end
		check_count($sformatf("wait cycles word 0x%0h", idx), waits, expected_waits(idx));
		check_bit($sformatf("pi1_err_o word 0x%0h", idx), err_seen, !in_map);
	endtask

	task automatic read_back_all();
		for (int i = 0; i < MAP_WORDS; i++) begin
			access_word(pi1_pkg::PI_RDOP, i, '0, '0);
		end
	endtask

	// **********************************************************************
	// Directed tests
	// **********************************************************************

	task automatic test_reset();
		check_bit("pi1_rdy_o after reset", pi1_rdy_o, 1'b1);
		check_bit("pi1_err_o after reset", pi1_err_o, 1'b0);
		check_data("pi1_data_o after reset", pi1_data_o, '0);
		check_addr("pi1_mapsz_o", pi1_mapsz_o, pi1_pkg::pi1_addr_t'(MAP_WORDS));
	endtask

	task automatic test_full_word();
		int samples [10] = '{0, 1, 128, 254, 255, 256, 257, 320, 382, 383};
		for (int i = 0; i < MAP_WORDS; i++) begin
			access_word(pi1_pkg::PI_WROP, i, $urandom, 4'hf);
		end
		foreach (samples[k]) begin
			access_word(pi1_pkg::PI_RDOP, samples[k], '0, '0);
		end
		for (int k = 0; k < 8; k++) begin
			access_word(pi1_pkg::PI_RDOP, int'($urandom_range(MAP_WORDS - 1, 0)), '0, '0);
		end
	endtask

	task automatic test_byte_merge();
		int idx;
		for (int k = 0; k < 48; k++) begin
			idx = int'($urandom_range(MAP_WORDS - 1, 0));
			access_word(pi1_pkg::PI_WROP, idx, $urandom, pi1_pkg::pi1_sel_t'($urandom));
			access_word(pi1_pkg::PI_RDOP, idx, '0, '0);
		end
	endtask

	task automatic test_read_write();
		int idx [8] = '{3, 255, 256, 383, 0, 0, 0, 0};
		for (int k = 4; k < 8; k++) begin
			idx[k] = int'($urandom_range(MAP_WORDS - 1, 0));
		end
		foreach (idx[k]) begin
			access_word(pi1_pkg::PI_RWOP, idx[k], $urandom, pi1_pkg::pi1_sel_t'($urandom));
			access_word(pi1_pkg::PI_RDOP, idx[k], '0, '0);
		end
	endtask

	// Alternates between the regions so each slave answers right after the other.
	task automatic test_wait_timing();
		pi1_pkg::pi1_op_t ops [3] = '{pi1_pkg::PI_WROP, pi1_pkg::PI_RDOP, pi1_pkg::PI_RWOP};
		foreach (ops[k]) begin
			access_word(ops[k], 20 + k, $urandom, 4'hf);
			access_word(ops[k], 300 + k, $urandom, 4'hf);
			access_word(ops[k], 301 + k, $urandom, 4'h5);
			access_word(ops[k], 21 + k, $urandom, 4'ha);
		end
	endtask

	task automatic test_out_of_range();
		int bad [5] = '{384, 385, 511, 1000, 30'h3fff_ffff};
		pi1_pkg::pi1_op_t ops [3] = '{pi1_pkg::PI_WROP, pi1_pkg::PI_RDOP, pi1_pkg::PI_RWOP};
		foreach (bad[a]) begin
			foreach (ops[k]) begin
				access_word(ops[k], bad[a], $urandom, 4'hf);
				@(negedge clk_i);
				check_bit("pi1_err_o after the pulse", pi1_err_o, 1'b0);
				check_bit("pi1_rdy_o after a miss", pi1_rdy_o, 1'b1);
			end
		end
		read_back_all();
	endtask

	initial begin
		rst_i      = 1'b1;
		pi1_op_i   = pi1_pkg::PI_NOOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		checks     = 0;
		errors     = 0;
		void'($urandom(32'h366c));
		for (int i = 0; i < MAP_WORDS; i++) begin
			model[i] = '0;
		end
		repeat (4) @(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		test_reset();
		test_full_word();
		test_byte_merge();
		test_read_write();
		test_wait_timing();
		test_out_of_range();
		assert_fails = u_pi1_mem_top.u_mem0.u_smem_asserts.fail_cnt +
			u_pi1_mem_top.u_mem1.u_smem_asserts.fail_cnt;
		$display("Checks: %0d  Errors: %0d  Assertion failures: %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
source/pi1_pkg.sv
source/pi1_ram.sv
source/pi1_smem.sv
source/pi1_decoder.sv
source/pi1_mem_top.sv
verif/pi1_smem_asserts.sv
verif/tb_pi1_mem.sv

// File: Makefile
# Verilator build and run for the pi1 memory subsystem.

VERILATOR ?= verilator
TOP       ?= tb_pi1_mem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
